// ==== design/cache_geom_pkg.sv ====
package cache_geom_pkg;

	// 8 sets of 64-bit lines by default.
	localparam int DEF_SET_BITS  = 3;
	localparam int DEF_LINE_BITS = 64;

	// line address width, tag in the upper bits and set index in the lower bits.
	localparam int ADDR_BITS = 16;

	// a two-bit field carries one bit per way, bit 0 for way 0.
	typedef struct packed {
		logic       read_data;
		logic       load_lru;
		logic [1:0] load_data;
		logic [1:0] load_tag;
		logic [1:0] set_valid;
		logic [1:0] set_dirty;
		logic [1:0] clear_dirty;
	} ctrl_cmd_t;

	// dirty and lru both describe the replacement way of the current set.
	typedef struct packed {
		logic       hit;
		logic [1:0] way_hit;
		logic       dirty;
		logic       lru;
	} way_status_t;

	typedef enum logic [1:0] {
		idle,
		hit_detection,
		load,
		store
	} ctrl_state_e;

endpackage : cache_geom_pkg

// ==== design/mem_bus_pkg.sv ====
package mem_bus_pkg;

	import cache_geom_pkg::*;

	// requester side, one whole line per access.
	typedef struct packed {
		logic                     read;
		logic                     write;
		logic [ADDR_BITS-1:0]     addr;
		logic [DEF_LINE_BITS-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic                     resp;
		logic [DEF_LINE_BITS-1:0] rdata;
	} cpu_rsp_t;

	// physical memory side.
	typedef struct packed {
		logic                     read;
		logic                     write;
		logic [ADDR_BITS-1:0]     addr;
		logic [DEF_LINE_BITS-1:0] wdata;
	} pmem_req_t;

	typedef struct packed {
		logic                     resp;
		logic [DEF_LINE_BITS-1:0] rdata;
	} pmem_rsp_t;

endpackage : mem_bus_pkg

// ==== design/l2_cache_control.sv ====
`timescale 1ns/1ps

module l2_cache_control
	import cache_geom_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cpu_read,
	input  logic        cpu_write,
	input  logic        pmem_resp,
	input  way_status_t status,
	output ctrl_cmd_t   cmd,
	output logic        pmem_read,
	output logic        pmem_write,
	output logic        cpu_resp
);

	ctrl_state_e state;
	ctrl_state_e next_state;
	logic [1:0]  lru_sel;

	// one-hot select of the replacement way.
	assign lru_sel = {status.lru, ~status.lru};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		unique case (state)
			idle: begin
				if (cpu_read | cpu_write)
					next_state = hit_detection;
			end
			hit_detection: begin
				if (status.hit)
					next_state = idle;
				else if (status.dirty)
					next_state = store;
				else
					next_state = load;
			end
			load: begin
				// after the fill the access is retried and completes as a hit.
				if (pmem_resp)
					next_state = hit_detection;
			end
			store: begin
				if (pmem_resp)
					next_state = load;
			end
			default: next_state = idle;
		endcase
	end

	always_comb begin
		cmd        = '0;
		pmem_read  = 1'b0;
		pmem_write = 1'b0;
		cpu_resp   = 1'b0;
		unique case (state)
			idle: begin
				cmd.read_data = cpu_read | cpu_write;
			end
			hit_detection: begin
				if (status.hit) begin
					cmd.load_lru = 1'b1;
					cpu_resp     = 1'b1;
					if (cpu_write) begin
						cmd.load_data = status.way_hit;
						cmd.set_dirty = status.way_hit;
					end
				end else if (!status.dirty) begin
					// clean victim, so the fetch can start right away.
					pmem_read = 1'b1;
				end
			end
			load: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					cmd.load_data = lru_sel;
					cmd.load_tag  = lru_sel;
					cmd.set_valid = lru_sel;
				end
			end
			store: begin
				pmem_write = 1'b1;
				// the dirty bit drops only with the response so the address stays on the victim.
				if (pmem_resp)
					cmd.clear_dirty = lru_sel;
			end
			default: begin
				cmd = '0;
			end
		endcase
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write))
		else $error("pmem read and write raised together in state %s", state.name());

	// a response answers a held request and comes from exactly one way.
	assert property (@(posedge clk) disable iff (!rst_n)
		cpu_resp |-> (cpu_read || cpu_write) && $onehot(status.way_hit))
		else $error("cpu resp without a held request and a single hit way in state %s",
			state.name());

	assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(state))
		else $error("controller state unknown after reset");

endmodule : l2_cache_control

// ==== design/l2_cache_datapath.sv ====
`timescale 1ns/1ps

module l2_cache_datapath
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
#(
	parameter int SET_BITS  = DEF_SET_BITS,
	parameter int LINE_BITS = DEF_LINE_BITS
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ctrl_cmd_t            cmd,
	input  cpu_req_t             cpu_req,
	input  logic [LINE_BITS-1:0] pmem_rdata,
	output way_status_t          status,
	output logic [LINE_BITS-1:0] rdata,
	output logic [LINE_BITS-1:0] pmem_wdata,
	output logic [ADDR_BITS-1:0] pmem_addr
);

	localparam int TAG_BITS = ADDR_BITS - SET_BITS;
	localparam int NUM_SETS = 1 << SET_BITS;

	logic [ADDR_BITS-1:0] req_addr;
	logic [LINE_BITS-1:0] req_wdata;
	logic [TAG_BITS-1:0]  req_tag;
	logic [SET_BITS-1:0]  req_idx;

	logic [TAG_BITS-1:0]  tag_arr   [2][NUM_SETS];
	logic [LINE_BITS-1:0] data_arr  [2][NUM_SETS];
	logic [NUM_SETS-1:0]  valid_arr [2];
	logic [NUM_SETS-1:0]  dirty_arr [2];
	logic [NUM_SETS-1:0]  lru_arr;

	logic [1:0]          way_hit;
	logic                lru_way;
	logic                victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;

	assign req_tag = req_addr[ADDR_BITS-1:SET_BITS];
	assign req_idx = req_addr[SET_BITS-1:0];

	// the request stays latched for the whole access, fills included.
	always_ff @(posedge clk) begin
		if (cmd.read_data) begin
			req_addr  <= cpu_req.addr;
			req_wdata <= cpu_req.wdata;
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (cmd.load_tag[w])
				tag_arr[w][req_idx] <= req_tag;
			// a fill always loads the tag too, which tells it apart from a write hit.
			if (cmd.load_data[w])
				data_arr[w][req_idx] <= cmd.load_tag[w] ? pmem_rdata : req_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int w = 0; w < 2; w++) begin
				valid_arr[w] <= '0;
				dirty_arr[w] <= '0;
			end
			lru_arr <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (cmd.set_valid[w])
					valid_arr[w][req_idx] <= 1'b1;
				if (cmd.set_dirty[w])
					dirty_arr[w][req_idx] <= 1'b1;
				else if (cmd.clear_dirty[w])
					dirty_arr[w][req_idx] <= 1'b0;
			end
			// point at the way that was not hit.
			if (cmd.load_lru)
				lru_arr[req_idx] <= way_hit[0];
		end
	end

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_arr[w][req_idx] && (tag_arr[w][req_idx] == req_tag);
		end
	end

	assign lru_way      = lru_arr[req_idx];
	assign victim_dirty = dirty_arr[lru_way][req_idx];
	assign victim_tag   = tag_arr[lru_way][req_idx];

	assign status.hit     = |way_hit;
	assign status.way_hit = way_hit;
	assign status.dirty   = victim_dirty;
	assign status.lru     = lru_way;

	assign rdata      = way_hit[1] ? data_arr[1][req_idx] : data_arr[0][req_idx];
	assign pmem_wdata = data_arr[lru_way][req_idx];

	// Writeback goes to the victim's own address, everything else to the request.
	always_comb begin
		if (victim_dirty && !way_hit[lru_way])
			pmem_addr = {victim_tag, req_idx};
		else
			pmem_addr = {req_tag, req_idx};
	end

	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(way_hit))
		else $error("both ways hit in set %0d", req_idx);

endmodule : l2_cache_datapath

// ==== design/l2_cache.sv ====
`timescale 1ns/1ps

module l2_cache
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
#(
	parameter int SET_BITS  = DEF_SET_BITS,
	parameter int LINE_BITS = DEF_LINE_BITS
) (
	input  logic      clk,
	input  logic      rst_n,
	input  cpu_req_t  cpu_req,
	output cpu_rsp_t  cpu_rsp,
	output pmem_req_t pmem_req,
	input  pmem_rsp_t pmem_rsp
);

	ctrl_cmd_t            cmd;
	way_status_t          status;
	logic                 pmem_read;
	logic                 pmem_write;
	logic                 cpu_resp;
	logic [LINE_BITS-1:0] rdata;
	logic [LINE_BITS-1:0] pmem_wdata;
	logic [ADDR_BITS-1:0] pmem_addr;

	l2_cache_control control_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_read   (cpu_req.read),
		.cpu_write  (cpu_req.write),
		.pmem_resp  (pmem_rsp.resp),
		.status     (status),
		.cmd        (cmd),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write),
		.cpu_resp   (cpu_resp)
	);

	l2_cache_datapath #(
		.SET_BITS  (SET_BITS),
		.LINE_BITS (LINE_BITS)
	) datapath_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.cpu_req    (cpu_req),
		.pmem_rdata (pmem_rsp.rdata),
		.status     (status),
		.rdata      (rdata),
		.pmem_wdata (pmem_wdata),
		.pmem_addr  (pmem_addr)
	);

	assign cpu_rsp.resp  = cpu_resp;
	assign cpu_rsp.rdata = rdata;

	// control bits from the FSM, address and line from the datapath.
	assign pmem_req.read  = pmem_read;
	assign pmem_req.write = pmem_write;
	assign pmem_req.addr  = pmem_addr;
	assign pmem_req.wdata = pmem_wdata;

endmodule : l2_cache

// ==== sim/pmem_model.sv ====
`timescale 1ns/1ps

module pmem_model
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  pmem_req_t                req,
	output pmem_rsp_t                rsp,
	output logic [ADDR_BITS-1:0]     last_addr,
	output logic [DEF_LINE_BITS-1:0] last_data,
	output int unsigned              write_count
);

	localparam int NUM_LINES = 1 << ADDR_BITS;

	logic [DEF_LINE_BITS-1:0] mem [NUM_LINES];
	logic [15:0]              lfsr_state;
	logic [1:0]               wait_cnt;

	// 16-bit Fibonacci LFSR, taps 16, 14, 13 and 11.
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return lfsr_state[0];
	endfunction

	initial begin
		lfsr_state = 16'd1873;
		for (int a = 0; a < NUM_LINES; a++) begin
			for (int b = 0; b < DEF_LINE_BITS; b++) begin
				mem[a][b] = next_random_bit();
			end
		end
	end

	// a request is answered on the third edge after it rises.
	always @(posedge clk) begin
		if (!rst_n) begin
			rsp         <= '0;
			wait_cnt    <= 2'd0;
			write_count <= 0;
			last_addr   <= '0;
			last_data   <= '0;
		end else begin
			rsp.resp <= 1'b0;
			if (rsp.resp) begin
				wait_cnt <= 2'd0;
			end else if (req.read || req.write) begin
				if (wait_cnt == 2'd2) begin
					wait_cnt <= 2'd0;
					rsp.resp <= 1'b1;
					if (req.read) begin
						rsp.rdata <= mem[req.addr];
					end else begin
						mem[req.addr] <= req.wdata;
						last_addr     <= req.addr;
						last_data     <= req.wdata;
						write_count   <= write_count + 1;
					end
				end else begin
					wait_cnt <= wait_cnt + 2'd1;
				end
			end
		end
	end

endmodule : pmem_model

// ==== sim/tb_l2_cache.sv ====
`timescale 1ns/1ps

module tb_l2_cache
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
();

	localparam int TIMEOUT   = 50;
	localparam int NUM_SETS  = 1 << DEF_SET_BITS;
	localparam int TAG_BITS  = ADDR_BITS - DEF_SET_BITS;
	localparam int NUM_LINES = 1 << ADDR_BITS;

	typedef enum logic {op_read, op_write} op_e;

	typedef struct {
		string                    name;
		op_e                      op;
		logic [ADDR_BITS-1:0]     addr;
		logic [DEF_LINE_BITS-1:0] wdata;
		bit                       exp_hit;
		bit                       exp_wb;
	} test_entry_t;

	logic      clk;
	logic      rst_n;
	cpu_req_t  cpu_req;
	cpu_rsp_t  cpu_rsp;
	pmem_req_t pmem_req;
	pmem_rsp_t pmem_rsp;

	logic [ADDR_BITS-1:0]     last_addr;
	logic [DEF_LINE_BITS-1:0] last_data;
	int unsigned              write_count;

	test_entry_t table_q[$];

	// reference model: shadow memory plus a two-way LRU cache.
	logic [DEF_LINE_BITS-1:0] shadow [NUM_LINES];
	logic [15:0]              lfsr_state;
	bit                       ref_valid [2][NUM_SETS];
	bit                       ref_dirty [2][NUM_SETS];
	logic [TAG_BITS-1:0]      ref_tag   [2][NUM_SETS];
	logic [DEF_LINE_BITS-1:0] ref_data  [2][NUM_SETS];
	bit                       ref_lru   [NUM_SETS];

	l2_cache dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.cpu_req  (cpu_req),
		.cpu_rsp  (cpu_rsp),
		.pmem_req (pmem_req),
		.pmem_rsp (pmem_rsp)
	);

	pmem_model mem_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (pmem_req),
		.rsp         (pmem_rsp),
		.last_addr   (last_addr),
		.last_data   (last_data),
		.write_count (write_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return lfsr_state[0];
	endfunction

	task automatic report_and_stop(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic add_entry(input string name, input op_e op, input logic [ADDR_BITS-1:0] addr,
			input logic [DEF_LINE_BITS-1:0] wdata, input bit exp_hit, input bit exp_wb);
		test_entry_t e;
		e.name    = name;
		e.op      = op;
		e.addr    = addr;
		e.wdata   = wdata;
		e.exp_hit = exp_hit;
		e.exp_wb  = exp_wb;
		table_q.push_back(e);
	endtask

	// set 0 is used for the hit and dirty cases, set 1 for the clean eviction.
	task automatic build_table();
		add_entry("cold_read",    op_read,  16'h0010, '0, 1'b0, 1'b0);
		add_entry("read_hit",     op_read,  16'h0010, '0, 1'b1, 1'b0);
		add_entry("write_hit",    op_write, 16'h0010, 64'hdead_beef_0123_4567, 1'b1, 1'b0);
		add_entry("read_written", op_read,  16'h0010, '0, 1'b1, 1'b0);
		add_entry("fill_way_a",   op_read,  16'h0021, '0, 1'b0, 1'b0);
		add_entry("fill_way_b",   op_read,  16'h0041, '0, 1'b0, 1'b0);
		add_entry("evict_clean",  op_read,  16'h0061, '0, 1'b0, 1'b0);
		add_entry("kept_way_b",   op_read,  16'h0041, '0, 1'b1, 1'b0);
		add_entry("evicted_a",    op_read,  16'h0021, '0, 1'b0, 1'b0);
		add_entry("fill_free",    op_read,  16'h0018, '0, 1'b0, 1'b0);
		add_entry("evict_dirty",  op_read,  16'h0020, '0, 1'b0, 1'b1);
		add_entry("reread_old",   op_read,  16'h0010, '0, 1'b0, 1'b0);
	endtask

	task automatic model_access(input test_entry_t e, output logic [DEF_LINE_BITS-1:0] rdata,
			output bit hit, output bit wb, output logic [ADDR_BITS-1:0] wb_addr,
			output logic [DEF_LINE_BITS-1:0] wb_data);
		logic [TAG_BITS-1:0]       tag;
		int                        idx;
		int                        way;
		tag     = e.addr[ADDR_BITS-1:DEF_SET_BITS];
		idx     = int'(e.addr[DEF_SET_BITS-1:0]);
		hit     = 1'b0;
		wb      = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		way     = 0;
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			way = int'(ref_lru[idx]);
			if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
				wb      = 1'b1;
				wb_addr = {ref_tag[way][idx], e.addr[DEF_SET_BITS-1:0]};
				wb_data = ref_data[way][idx];
				shadow[wb_addr] = wb_data;
			end
			ref_valid[way][idx] = 1'b1;
			ref_dirty[way][idx] = 1'b0;
			ref_tag[way][idx]   = tag;
			ref_data[way][idx]  = shadow[e.addr];
		end
		if (e.op == op_write) begin
			ref_data[way][idx]  = e.wdata;
			ref_dirty[way][idx] = 1'b1;
		end
		ref_lru[idx] = (way == 0);
		rdata = ref_data[way][idx];
	endtask

	task automatic run_access(input test_entry_t e, output int cycles, output bit traffic,
			output logic [DEF_LINE_BITS-1:0] rdata);
		bit done;
		@(posedge clk);
		#1;
		cpu_req.read  = (e.op == op_read);
		cpu_req.write = (e.op == op_write);
		cpu_req.addr  = e.addr;
		cpu_req.wdata = e.wdata;
		cycles  = 0;
		traffic = 1'b0;
		done    = 1'b0;
		rdata   = '0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (pmem_req.read || pmem_req.write)
				traffic = 1'b1;
			if (cpu_rsp.resp) begin
				done  = 1'b1;
				rdata = cpu_rsp.rdata;
			end else if (cycles >= TIMEOUT) begin
				report_and_stop($sformatf("Timeout: the cache never answered the %s access.",
					e.name));
			end
		end
		@(posedge clk);
		#1;
		cpu_req = '0;
	endtask

	initial begin
		logic [DEF_LINE_BITS-1:0] exp_rdata;
		logic [DEF_LINE_BITS-1:0] act_rdata;
		logic [DEF_LINE_BITS-1:0] wb_data;
		logic [ADDR_BITS-1:0]     wb_addr;
		bit                       hit;
		bit                       wb;
		bit                       traffic;
		int                       cycles;
		int unsigned              writes_before;
		test_entry_t              e;

		rst_n   = 1'b0;
		cpu_req = '0;
		lfsr_state = 16'd1873;
		for (int a = 0; a < NUM_LINES; a++) begin
			for (int b = 0; b < DEF_LINE_BITS; b++) begin
				shadow[a][b] = lfsr_bit();
			end
		end
		for (int s = 0; s < NUM_SETS; s++) begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				ref_valid[w][s] = 1'b0;
				ref_dirty[w][s] = 1'b0;
			end
		end
		build_table();

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		assert (!cpu_rsp.resp && !pmem_req.read && !pmem_req.write)
		else report_and_stop("Outputs were not idle after reset.");

		foreach (table_q[i]) begin
			e = table_q[i];
			model_access(e, exp_rdata, hit, wb, wb_addr, wb_data);
			assert (hit == e.exp_hit && wb == e.exp_wb)
			else report_and_stop($sformatf("Reference model disagrees with the table at %s.",
				e.name));
			writes_before = write_count;
			run_access(e, cycles, traffic, act_rdata);
			assert (!traffic == e.exp_hit)
			else report_and_stop($sformatf("Error: %s hit expected %0d actual %0d",
				e.name, e.exp_hit, !traffic));
			if (e.exp_hit) begin
				assert (cycles == 2)
				else report_and_stop($sformatf("Error: %s latency expected 2 actual %0d",
					e.name, cycles));
			end
			if (e.op == op_read) begin
				assert (act_rdata === exp_rdata)
				else report_and_stop($sformatf("Error: %s rdata expected %h actual %h",
					e.name, exp_rdata, act_rdata));
			end
			assert (write_count - writes_before == (wb ? 1 : 0))
			else report_and_stop($sformatf("Error: %s writes expected %0d actual %0d",
				e.name, wb, write_count - writes_before));
			if (wb) begin
				assert (last_addr == wb_addr && last_data == wb_data)
				else report_and_stop($sformatf("Error: %s writeback expected %h:%h actual %h:%h",
					e.name, wb_addr, wb_data, last_addr, last_data));
			end
		end

		$display(">>> PASS");
		$finish;
	end

endmodule : tb_l2_cache

// ==== l2_cache.f ====
design/cache_geom_pkg.sv
design/mem_bus_pkg.sv
design/l2_cache_control.sv
design/l2_cache_datapath.sv
design/l2_cache.sv
sim/pmem_model.sv
sim/tb_l2_cache.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build products and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f l2_cache.f --top-module tb_l2_cache -o sim_l2_cache
	-./obj_dir/sim_l2_cache > sim.log 2>&1
	@cat sim.log
	@grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log
